//--- project.f
+incdir+verif
src/usb_capture_pkg.sv
src/usb_line_decoder.sv
src/usb_packet_capture.sv
src/capture_fifo.sv
src/usb_capture_top.sv
verif/usb_capture_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the usb capture testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module usb_capture_tb \
    -f project.f -Mdir obj_dir -o usb_capture_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/usb_capture_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- src/capture_fifo.sv
// tagged entry fifo with valid/ready read side and saturating drop counter
module capture_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  usb_capture_pkg::tag_t   wr_tag,
    input  usb_capture_pkg::byte_t  wr_data,
    input  logic                    out_ready,
    output logic                    out_valid,
    output usb_capture_pkg::tag_t   out_tag,
    output usb_capture_pkg::byte_t  out_data,
    output usb_capture_pkg::count_t drop_count
);
    import usb_capture_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    entry_t mem [FIFO_DEPTH];
    entry_t head;
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic full;
    logic rd_fire;
    logic wr_accept;
    logic wr_drop;

    // extra pointer bit tells full from empty
    assign full      = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign out_valid = (wr_ptr != rd_ptr);
    assign rd_fire   = out_valid && out_ready;
    // a read frees the slot in the same cycle
    assign wr_accept = wr_en && (!full || rd_fire);
    assign wr_drop   = wr_en && full && !rd_fire;

    assign head                = mem[rd_ptr[ADDR_W-1:0]];
    assign {out_tag, out_data} = head;

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {wr_tag, wr_data};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            drop_count <= 8'd0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_drop && drop_count != 8'hFF) begin
                drop_count <= drop_count + 8'd1;
            end
        end
    end

endmodule

//--- src/usb_capture_pkg.sv
// shared widths, fifo entry tags, pid values and capture state enum
package usb_capture_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [1:0] tag_t;
    typedef logic [7:0] count_t;
    // tag in the upper bits, byte below
    typedef logic [9:0] entry_t;

    localparam tag_t TAG_PID     = 2'd0;
    localparam tag_t TAG_DATA    = 2'd1;
    localparam tag_t TAG_END_OK  = 2'd2;
    localparam tag_t TAG_END_ERR = 2'd3;

    // decoded lsb first, seven zeros then a one
    localparam byte_t SYNC_BYTE = 8'h80;

    // full pid bytes, check nibble in the upper half
    localparam byte_t PID_OUT   = 8'hE1;
    localparam byte_t PID_IN    = 8'h69;
    localparam byte_t PID_SOF   = 8'hA5;
    localparam byte_t PID_SETUP = 8'h2D;
    localparam byte_t PID_DATA0 = 8'hC3;
    localparam byte_t PID_DATA1 = 8'h4B;
    localparam byte_t PID_ACK   = 8'hD2;
    localparam byte_t PID_NAK   = 8'h5A;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        SYNC = 3'd1,
        PID  = 3'd2,
        DATA = 3'd3,
        EOP  = 3'd4
    } capture_state_t;

endpackage

//--- src/usb_capture_top.sv
// capture subsystem top: line decoder, packet capture and output fifo
module usb_capture_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dp,
    input  logic                    dm,
    input  logic                    start_capture,
    input  logic                    out_ready,
    output logic                    out_valid,
    output usb_capture_pkg::tag_t   out_tag,
    output usb_capture_pkg::byte_t  out_data,
    output usb_capture_pkg::count_t packets_captured,
    output usb_capture_pkg::count_t drop_count
);
    import usb_capture_pkg::*;

    logic bit_valid;
    logic bit_value;
    logic line_se0;
    logic line_k;
    logic wr_en;
    tag_t wr_tag;
    byte_t wr_data;

    usb_line_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .dp        (dp),
        .dm        (dm),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .line_se0  (line_se0),
        .line_k    (line_k)
    );

    usb_packet_capture u_capture (
        .clk              (clk),
        .reset            (reset),
        .start_capture    (start_capture),
        .bit_valid        (bit_valid),
        .bit_value        (bit_value),
        .line_se0         (line_se0),
        .line_k           (line_k),
        .wr_en            (wr_en),
        .wr_tag           (wr_tag),
        .wr_data          (wr_data),
        .packets_captured (packets_captured)
    );

    capture_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_tag     (wr_tag),
        .wr_data    (wr_data),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_tag    (out_tag),
        .out_data   (out_data),
        .drop_count (drop_count)
    );

endmodule

//--- src/usb_line_decoder.sv
// line synchronizer, j/k/se0 classification, nrzi decoder and bit unstuffer
module usb_line_decoder (
    input  logic clk,
    input  logic reset,
    input  logic dp,
    input  logic dm,
    output logic bit_valid,
    output logic bit_value,
    output logic line_se0,
    output logic line_k
);

    logic dp_s1;
    logic dm_s1;
    logic dp_s2;
    logic dm_s2;
    logic line_j;
    logic prev_j;
    logic nrzi_bit;
    logic in_packet;
    logic [2:0] ones_cnt;

    // two flop synchronizer, parked at j
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dp_s1 <= 1'b1;
            dm_s1 <= 1'b0;
            dp_s2 <= 1'b1;
            dm_s2 <= 1'b0;
        end else begin
            dp_s1 <= dp;
            dm_s1 <= dm;
            dp_s2 <= dp_s1;
            dm_s2 <= dm_s1;
        end
    end

    assign line_j   = dp_s2 & ~dm_s2;
    assign line_k   = ~dp_s2 & dm_s2;
    assign line_se0 = ~dp_s2 & ~dm_s2;

    // no transition decodes as one
    assign nrzi_bit = (line_j == prev_j);

    // stuffing is only tracked once the first transition after idle has been seen,
    // so a long idle j run can never swallow the first sync bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_valid <= 1'b0;
            bit_value <= 1'b0;
            prev_j    <= 1'b1;
            in_packet <= 1'b0;
            ones_cnt  <= 3'd0;
        end else begin
            bit_valid <= 1'b0;
            if (line_se0) begin
                prev_j    <= 1'b1;
                in_packet <= 1'b0;
                ones_cnt  <= 3'd0;
            end else if (line_j || line_k) begin
                prev_j    <= line_j;
                bit_value <= nrzi_bit;
                if (in_packet && ones_cnt == 3'd6) begin
                    // stuffed zero, dropped
                    ones_cnt <= 3'd0;
                end else begin
                    bit_valid <= 1'b1;
                    if (!nrzi_bit) begin
                        ones_cnt  <= 3'd0;
                        in_packet <= 1'b1;
                    end else if (in_packet) begin
                        ones_cnt <= ones_cnt + 3'd1;
                    end
                end
            end
        end
    end

endmodule

//--- src/usb_packet_capture.sv
// packet capture fsm: sync hunt, pid check, byte assembly, end markers, packet count
module usb_packet_capture (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_capture,
    input  logic                    bit_valid,
    input  logic                    bit_value,
    input  logic                    line_se0,
    input  logic                    line_k,
    output logic                    wr_en,
    output usb_capture_pkg::tag_t   wr_tag,
    output usb_capture_pkg::byte_t  wr_data,
    output usb_capture_pkg::count_t packets_captured
);
    import usb_capture_pkg::*;

    capture_state_t state;
    capture_state_t state_n;
    logic [2:0] bit_cnt;
    logic [2:0] bit_cnt_n;
    byte_t shift_reg;
    byte_t byte_next;
    logic byte_done;
    logic pid_err;
    logic pid_err_n;
    byte_t data_cnt;
    byte_t data_cnt_n;
    count_t pkt_cnt_n;
    logic wr_en_n;
    tag_t wr_tag_n;
    byte_t wr_data_n;

    // lsb first
    assign byte_next = {bit_value, shift_reg[7:1]};
    assign byte_done = bit_valid && (bit_cnt == 3'd7);

    always_comb begin
        state_n    = state;
        bit_cnt_n  = bit_cnt;
        pid_err_n  = pid_err;
        data_cnt_n = data_cnt;
        pkt_cnt_n  = packets_captured;
        wr_en_n    = 1'b0;
        wr_tag_n   = TAG_DATA;
        wr_data_n  = byte_next;

        if (bit_valid && state != IDLE && state != EOP) begin
            bit_cnt_n = bit_cnt + 3'd1;
        end

        case (state)
            IDLE: begin
                bit_cnt_n  = 3'd0;
                pid_err_n  = 1'b0;
                data_cnt_n = 8'd0;
                if (start_capture && line_k) begin
                    state_n = SYNC;
                end
            end
            SYNC: begin
                if (line_se0) begin
                    state_n = IDLE;
                end else if (byte_done) begin
                    state_n = (byte_next == SYNC_BYTE) ? PID : IDLE;
                end
            end
            PID: begin
                if (byte_done) begin
                    wr_en_n   = 1'b1;
                    wr_tag_n  = TAG_PID;
                    pid_err_n = (byte_next[3:0] != ~byte_next[7:4]);
                    state_n   = DATA;
                end else if (line_se0) begin
                    // cut short before the pid was complete
                    wr_en_n   = 1'b1;
                    wr_tag_n  = TAG_END_ERR;
                    wr_data_n = data_cnt;
                    pkt_cnt_n = packets_captured + 8'd1;
                    state_n   = EOP;
                end
            end
            DATA: begin
                // a byte finishing alongside se0 goes first, the
                // second se0 bit then closes the packet
                if (byte_done) begin
                    wr_en_n    = 1'b1;
                    wr_tag_n   = TAG_DATA;
                    data_cnt_n = data_cnt + 8'd1;
                end else if (line_se0) begin
                    wr_en_n   = 1'b1;
                    wr_data_n = data_cnt;
                    if (pid_err || bit_cnt != 3'd0 || bit_valid) begin
                        wr_tag_n = TAG_END_ERR;
                    end else begin
                        wr_tag_n = TAG_END_OK;
                    end
                    pkt_cnt_n = packets_captured + 8'd1;
                    state_n   = EOP;
                end
            end
            EOP: begin
                if (!line_se0) begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= IDLE;
            bit_cnt          <= 3'd0;
            pid_err          <= 1'b0;
            data_cnt         <= 8'd0;
            packets_captured <= 8'd0;
            wr_en            <= 1'b0;
        end else begin
            state            <= state_n;
            bit_cnt          <= bit_cnt_n;
            pid_err          <= pid_err_n;
            data_cnt         <= data_cnt_n;
            packets_captured <= pkt_cnt_n;
            wr_en            <= wr_en_n;
        end
    end

    always_ff @(posedge clk) begin
        if (bit_valid) begin
            shift_reg <= byte_next;
        end
        wr_tag  <= wr_tag_n;
        wr_data <= wr_data_n;
    end

endmodule

//--- verif/usb_line_model.svh
// line model tasks: nrzi encoder with bit stuffing, packet framing, expected entry queue

// one line state, driven a short delay after the rising edge
task automatic drive_line(input logic p, input logic m);
    @(posedge clk);
    #1;
    dp = p;
    dm = m;
    bits_sent++;
endtask

task automatic send_idle(input int n);
    line_j = 1'b1;
    for (int i = 0; i < n; i++) begin
        drive_line(1'b1, 1'b0);
    end
endtask

// a zero toggles the line, six ones in a row force a stuffed zero
task automatic send_bit(input logic b);
    if (!b) begin
        line_j = ~line_j;
    end
    drive_line(line_j, ~line_j);
    if (b) begin
        ones_run++;
        if (ones_run == 6) begin
            line_j = ~line_j;
            drive_line(line_j, ~line_j);
            ones_run = 0;
        end
    end else begin
        ones_run = 0;
    end
endtask

task automatic send_byte(input byte_t value);
    for (int i = 0; i < 8; i++) begin
        send_bit(value[i]);
    end
endtask

// while the output is held, only the first fifo_depth entries survive
task automatic expect_entry(input tag_t tag, input byte_t value);
    if (!hold_mode) begin
        exp_q.push_back({tag, value});
    end else if (held < fifo_depth) begin
        exp_q.push_back({tag, value});
        held++;
    end else if (exp_drops < 255) begin
        exp_drops++;
    end
endtask

// expectations go in first, the pid entry leaves the dut before the eop is sent
task automatic send_packet(input bit armed, input bit bad_pid, input int n_data,
                           input bit all_ones);
    byte_t pid;
    byte_t payload [$];
    logic [3:0] pid_type;
    int flip;
    int idle_len;
    pid_type = 4'($urandom_range(0, 15));
    pid = {~pid_type, pid_type};
    if (bad_pid) begin
        flip = $urandom_range(4, 7);
        pid[flip] = ~pid[flip];
    end
    for (int i = 0; i < n_data; i++) begin
        payload.push_back(all_ones ? 8'hFF : 8'($urandom));
    end
    if (armed) begin
        armed_count++;
        expect_entry(TAG_PID, pid);
        foreach (payload[i]) begin
            expect_entry(TAG_DATA, payload[i]);
        end
        expect_entry(bad_pid ? TAG_END_ERR : TAG_END_OK, 8'(n_data));
    end
    idle_len = $urandom_range(4, 11);
    line_j = 1'b1;
    drive_line(1'b1, 1'b0);
    start_capture = armed;
    send_idle(idle_len - 1);
    ones_run = 0;
    // kjkjkjkk on the line
    send_byte(8'h80);
    send_byte(pid);
    foreach (payload[i]) begin
        send_byte(payload[i]);
    end
    drive_line(1'b0, 1'b0);
    drive_line(1'b0, 1'b0);
    drive_line(1'b1, 1'b0);
    line_j = 1'b1;
endtask

//--- verif/usb_capture_tb.sv
// testbench for the usb capture subsystem: clock, reset, scenarios, monitor, watchdog
module usb_capture_tb;
    import usb_capture_pkg::*;

    logic clk;
    logic reset;
    logic dp;
    logic dm;
    logic start_capture;
    logic out_ready;
    logic out_valid;
    tag_t out_tag;
    byte_t out_data;
    count_t packets_captured;
    count_t drop_count;

    logic [9:0] exp_q [$];
    logic [9:0] exp_entry;
    logic line_j;
    int ones_run;
    int bits_sent;
    int cycle_count;
    int armed_count;
    int exp_drops;
    int fifo_depth;
    int held;
    bit hold_mode;
    bit ready_random;
    capture_state_t stuck_state;

    usb_capture_top dut (
        .clk              (clk),
        .reset            (reset),
        .dp               (dp),
        .dm               (dm),
        .start_capture    (start_capture),
        .out_ready        (out_ready),
        .out_valid        (out_valid),
        .out_tag          (out_tag),
        .out_data         (out_data),
        .packets_captured (packets_captured),
        .drop_count       (drop_count)
    );

    `include "usb_line_model.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s mismatch, got %0h expected %0h",
                     $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic set_ready(input logic value);
        @(posedge clk);
        #1;
        out_ready = value;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic check_counts();
        compare(packets_captured, armed_count % 256, "packets_captured");
        compare(drop_count, exp_drops, "drop_count");
    endtask

    // output entries sampled at the falling edge
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("unexpected entry at time %0t: tag %0d data %0h",
                         $time, out_tag, out_data);
                $display("Simulation finished: FAIL");
                $fatal(1, "output entry with nothing expected");
            end else begin
                exp_entry = exp_q.pop_front();
                compare({out_tag, out_data}, exp_entry, "fifo entry");
            end
        end
    end

    always @(posedge clk) begin
        if (ready_random) begin
            #1;
            out_ready = ($urandom_range(0, 1) == 1);
        end
    end

    // limit grows with every bit time sent
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > bits_sent + 200) begin
            stuck_state = dut.u_capture.state;
            $display("timeout after %0d cycles: capture state %s, %0d entries still expected",
                     cycle_count, stuck_state.name(), exp_q.size());
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'h5188));
        reset = 1'b1;
        dp = 1'b1;
        dm = 1'b0;
        start_capture = 1'b0;
        out_ready = 1'b0;
        line_j = 1'b1;
        ones_run = 0;
        bits_sent = 0;
        armed_count = 0;
        exp_drops = 0;
        held = 0;
        hold_mode = 1'b0;
        ready_random = 1'b0;
        fifo_depth = dut.FIFO_DEPTH;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        out_ready = 1'b1;
        check_counts();

        // random valid packets
        for (int i = 0; i < 6; i++) begin
            send_packet(1'b1, 1'b0, $urandom_range(0, 12), 1'b0);
        end
        wait_drain();
        check_counts();

        // 0xff payloads whose stuffed bits must vanish
        for (int i = 0; i < 3; i++) begin
            send_packet(1'b1, 1'b0, $urandom_range(4, 12), 1'b1);
        end
        wait_drain();
        check_counts();

        // bad pid check nibble
        send_packet(1'b1, 1'b1, $urandom_range(0, 12), 1'b0);
        send_packet(1'b1, 1'b1, 0, 1'b0);
        wait_drain();
        check_counts();

        // not armed
        for (int i = 0; i < 3; i++) begin
            send_packet(1'b0, 1'b0, $urandom_range(0, 12), 1'b0);
        end
        wait_drain();
        check_counts();

        // burst into a stalled output
        set_ready(1'b0);
        held = 0;
        hold_mode = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_packet(1'b1, 1'b0, $urandom_range(4, 10), 1'b0);
        end
        send_idle(8);
        hold_mode = 1'b0;
        set_ready(1'b1);
        wait_drain();
        check_counts();

        // mixed packets under random back-pressure
        ready_random = 1'b1;
        for (int i = 0; i < 10; i++) begin
            send_packet($urandom_range(0, 3) != 0, $urandom_range(0, 3) == 0,
                        $urandom_range(0, 12), $urandom_range(0, 4) == 0);
        end
        wait_drain();
        ready_random = 1'b0;
        set_ready(1'b1);
        repeat (5) @(posedge clk);
        compare(out_valid, 1'b0, "out_valid after drain");
        check_counts();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
